// File: logic/tex_pkg.sv
package tex_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int PIXEL_W = 8;
    localparam int FRAC_W  = 4;     // fraction bits of coordinates and coefficients
    localparam int COEF_W  = 16;
    localparam int COORD_W = 20;

    // fixed point 1.0
    localparam int ONE = 1 << FRAC_W;

    // ----------------------------------------
    // bilinear arithmetic
    // ----------------------------------------
    localparam int WEIGHT_W    = FRAC_W + 1;            // 16 - f needs one extra bit
    localparam int PROD_W      = PIXEL_W + 2 * WEIGHT_W;
    localparam int SUM_W       = PROD_W + 2;            // four products
    localparam int BLEND_SHIFT = 2 * FRAC_W;            // weights sum to ONE*ONE
    localparam int BLEND_ROUND = 1 << (BLEND_SHIFT - 1);

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef logic        [PIXEL_W-1:0] pixel_t;
    typedef logic signed [COEF_W-1:0]  coef_t;   // 1/16 units
    typedef logic signed [COORD_W-1:0] coord_t;  // 4 fraction bits
    typedef logic        [FRAC_W-1:0]  frac_t;

endpackage

// File: logic/tex_ifs.sv
// texture coordinate stream, affine_scan to texel_fetch
interface coord_if
    import tex_pkg::*;
();
    coord_t u;
    coord_t v;
    logic   last;     // final raster pixel
    logic   valid;
    logic   ready;

    modport source (output u, v, last, valid, input ready);
    modport sink   (input u, v, last, valid, output ready);
endinterface

// four neighbour texels with their blend fractions
interface quad_if
    import tex_pkg::*;
();
    pixel_t t00;      // (x0, y0)
    pixel_t t01;      // (x1, y0)
    pixel_t t10;      // (x0, y1)
    pixel_t t11;      // (x1, y1)
    frac_t  fu;
    frac_t  fv;
    logic   border;
    logic   last;
    logic   valid;
    logic   ready;

    modport source (
        output t00, t01, t10, t11, fu, fv, border, last, valid,
        input  ready
    );
    modport sink (
        input  t00, t01, t10, t11, fu, fv, border, last, valid,
        output ready
    );
endinterface

// File: logic/affine_scan.sv
module affine_scan
    import tex_pkg::*;
#(
    parameter int OUT_W = 16,
    parameter int OUT_H = 16
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  coef_t   m00,
    input  coef_t   m01,
    input  coef_t   m02,
    input  coef_t   m10,
    input  coef_t   m11,
    input  coef_t   m12,
    output logic    busy,
    coord_if.source co
);

    localparam int XW = (OUT_W > 1) ? $clog2(OUT_W) : 1;
    localparam int YW = (OUT_H > 1) ? $clog2(OUT_H) : 1;

    logic [XW-1:0] x, nx, px;
    logic [YW-1:0] y, ny, py;
    logic          take;
    logic          load;
    logic          last_pos;
    int            u_acc;
    int            v_acc;

    assign take = co.valid && co.ready;
    assign load = (start && !busy) || (take && !co.last);

    // ----------------------------------------
    // raster position of the next coordinate
    // ----------------------------------------
    always_comb begin
        if (x == XW'(OUT_W - 1)) begin
            nx = '0;
            ny = y + YW'(1);
        end else begin
            nx = x + XW'(1);
            ny = y;
        end
        px = busy ? nx : '0;   // a new frame starts at the origin
        py = busy ? ny : '0;
        last_pos = (px == XW'(OUT_W - 1)) && (py == YW'(OUT_H - 1));
    end

    // ----------------------------------------
    // affine map in 1/16 units
    // ----------------------------------------
    always_comb begin
        u_acc = int'(m00) * int'(px) + int'(m01) * int'(py) + int'(m02);
        v_acc = int'(m10) * int'(px) + int'(m11) * int'(py) + int'(m12);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            co.valid <= 1'b0;
            x        <= '0;
            y        <= '0;
        end else if (start && !busy) begin
            busy     <= 1'b1;
            co.valid <= 1'b1;
            x        <= '0;
            y        <= '0;
        end else if (take) begin
            if (co.last) begin
                co.valid <= 1'b0;
            end else begin
                x <= nx;
                y <= ny;
            end
        end else if (busy && !co.valid) begin
            busy <= 1'b0;   // one cycle after the final transfer
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            co.u    <= coord_t'(u_acc);
            co.v    <= coord_t'(v_acc);
            co.last <= last_pos;
        end
    end

endmodule

// File: logic/texture_mem.sv
module texture_mem
    import tex_pkg::*;
#(
    parameter int TEX_X_BITS = 4,
    parameter int TEX_Y_BITS = 4
) (
    input  logic                             clk,
    input  logic                             we,
    input  logic [TEX_X_BITS+TEX_Y_BITS-1:0] waddr,
    input  pixel_t                           wdata,
    input  logic                             en,
    input  logic [TEX_X_BITS+TEX_Y_BITS-1:0] raddr0,
    input  logic [TEX_X_BITS+TEX_Y_BITS-1:0] raddr1,
    input  logic [TEX_X_BITS+TEX_Y_BITS-1:0] raddr2,
    input  logic [TEX_X_BITS+TEX_Y_BITS-1:0] raddr3,
    output pixel_t                           rdata0,
    output pixel_t                           rdata1,
    output pixel_t                           rdata2,
    output pixel_t                           rdata3
);

    localparam int DEPTH = 1 << (TEX_X_BITS + TEX_Y_BITS);

    pixel_t mem [DEPTH];   // row major, y * width + x

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // four reads, held while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            rdata0 <= mem[raddr0];
            rdata1 <= mem[raddr1];
            rdata2 <= mem[raddr2];
            rdata3 <= mem[raddr3];
        end
    end

endmodule

// File: logic/texel_fetch.sv
module texel_fetch
    import tex_pkg::*;
#(
    parameter int TEX_X_BITS = 4,
    parameter int TEX_Y_BITS = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             tex_we,
    input  logic [TEX_X_BITS+TEX_Y_BITS-1:0] tex_waddr,
    input  pixel_t                           tex_wdata,
    coord_if.sink                            ci,
    quad_if.source                           qo
);

    localparam int AW    = TEX_X_BITS + TEX_Y_BITS;
    localparam int TEX_W = 1 << TEX_X_BITS;
    localparam int TEX_H = 1 << TEX_Y_BITS;

    logic                 s1_valid;
    logic [3:0][AW-1:0]   s1_addr;
    frac_t                s1_fu;
    frac_t                s1_fv;
    logic                 s1_border;
    logic                 s1_last;
    logic                 s2_en;
    logic [3:0][AW-1:0]   addr;
    logic                 border;
    pixel_t               rd0, rd1, rd2, rd3;

    assign s2_en    = !qo.valid || qo.ready;
    assign ci.ready = !s1_valid || s2_en;

    // ----------------------------------------
    // integer split, border test, clamping
    // ----------------------------------------
    always_comb begin
        int x0, y0, x1, y1;
        x0 = int'(ci.u >>> FRAC_W);
        y0 = int'(ci.v >>> FRAC_W);
        border = (x0 < 0) || (y0 < 0) || (x0 >= TEX_W) || (y0 >= TEX_H);
        x1 = (x0 >= TEX_W - 1) ? TEX_W - 1 : x0 + 1;   // right edge repeats
        y1 = (y0 >= TEX_H - 1) ? TEX_H - 1 : y0 + 1;
        if (border) begin
            addr = '0;
        end else begin
            addr[0] = AW'(y0 * TEX_W + x0);
            addr[1] = AW'(y0 * TEX_W + x1);
            addr[2] = AW'(y1 * TEX_W + x0);
            addr[3] = AW'(y1 * TEX_W + x1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            qo.valid <= 1'b0;
        end else begin
            if (ci.ready) begin
                s1_valid <= ci.valid;
            end
            if (s2_en) begin
                qo.valid <= s1_valid;
            end
        end
    end

    // stage 1 payload
    always_ff @(posedge clk) begin
        if (ci.ready) begin
            s1_addr   <= addr;
            s1_fu     <= ci.u[FRAC_W-1:0];
            s1_fv     <= ci.v[FRAC_W-1:0];
            s1_border <= border;
            s1_last   <= ci.last;
        end
    end

    // stage 2 sidebands travel next to the memory read
    always_ff @(posedge clk) begin
        if (s2_en) begin
            qo.fu     <= s1_fu;
            qo.fv     <= s1_fv;
            qo.border <= s1_border;
            qo.last   <= s1_last;
        end
    end

    texture_mem #(
        .TEX_X_BITS (TEX_X_BITS),
        .TEX_Y_BITS (TEX_Y_BITS)
    ) i_texture_mem (
        .clk    (clk),
        .we     (tex_we),
        .waddr  (tex_waddr),
        .wdata  (tex_wdata),
        .en     (s2_en),
        .raddr0 (s1_addr[0]),
        .raddr1 (s1_addr[1]),
        .raddr2 (s1_addr[2]),
        .raddr3 (s1_addr[3]),
        .rdata0 (rd0),
        .rdata1 (rd1),
        .rdata2 (rd2),
        .rdata3 (rd3)
    );

    assign qo.t00 = rd0;
    assign qo.t01 = rd1;
    assign qo.t10 = rd2;
    assign qo.t11 = rd3;

endmodule

// File: logic/bilinear_blend.sv
module bilinear_blend
    import tex_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  pixel_t border_value,
    quad_if.sink   qi,
    output pixel_t data,
    output logic   border,
    output logic   last,
    output logic   valid,
    input  logic   ready
);

    logic [WEIGHT_W-1:0]   wu0, wu1, wv0, wv1;
    logic                  s1_valid;
    logic [3:0][PROD_W-1:0] s1_prod;
    logic                  s1_border;
    logic                  s1_last;
    logic                  s2_en;
    logic [SUM_W-1:0]      sum;

    assign s2_en    = !valid || ready;
    assign qi.ready = !s1_valid || s2_en;

    // ----------------------------------------
    // stage 1, weighted texels
    // ----------------------------------------
    always_comb begin
        wu1 = {1'b0, qi.fu};
        wv1 = {1'b0, qi.fv};
        wu0 = WEIGHT_W'(ONE) - wu1;
        wv0 = WEIGHT_W'(ONE) - wv1;
    end

    always_ff @(posedge clk) begin
        if (qi.ready) begin
            s1_prod[0] <= PROD_W'(qi.t00) * PROD_W'(wu0) * PROD_W'(wv0);
            s1_prod[1] <= PROD_W'(qi.t01) * PROD_W'(wu1) * PROD_W'(wv0);
            s1_prod[2] <= PROD_W'(qi.t10) * PROD_W'(wu0) * PROD_W'(wv1);
            s1_prod[3] <= PROD_W'(qi.t11) * PROD_W'(wu1) * PROD_W'(wv1);
            s1_border  <= qi.border;
            s1_last    <= qi.last;
        end
    end

    // ----------------------------------------
    // stage 2, sum and round
    // ----------------------------------------
    assign sum = SUM_W'(s1_prod[0]) + SUM_W'(s1_prod[1]) + SUM_W'(s1_prod[2])
               + SUM_W'(s1_prod[3]) + SUM_W'(BLEND_ROUND);

    always_ff @(posedge clk) begin
        if (s2_en) begin
            data   <= s1_border ? border_value : pixel_t'(sum >> BLEND_SHIFT);
            border <= s1_border;
            last   <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            valid    <= 1'b0;
        end else begin
            if (qi.ready) begin
                s1_valid <= qi.valid;
            end
            if (s2_en) begin
                valid <= s1_valid;
            end
        end
    end

endmodule

// File: logic/tex_sampler_top.sv
module tex_sampler_top
    import tex_pkg::*;
#(
    parameter int TEX_X_BITS = 4,
    parameter int TEX_Y_BITS = 4,
    parameter int OUT_W      = 16,
    parameter int OUT_H      = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             tex_we,
    input  logic [TEX_X_BITS+TEX_Y_BITS-1:0] tex_waddr,
    input  pixel_t                           tex_wdata,
    input  coef_t                            m00,
    input  coef_t                            m01,
    input  coef_t                            m02,
    input  coef_t                            m10,
    input  coef_t                            m11,
    input  coef_t                            m12,
    input  pixel_t                           border_value,
    input  logic                             out_ready,
    output logic                             busy,
    output pixel_t                           out_data,
    output logic                             out_border,
    output logic                             out_last,
    output logic                             out_valid
);

    coord_if coord_link ();
    quad_if  quad_link ();

    // ----------------------------------------
    // scan, fetch, blend
    // ----------------------------------------
    affine_scan #(
        .OUT_W (OUT_W),
        .OUT_H (OUT_H)
    ) i_affine_scan (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .m00   (m00),
        .m01   (m01),
        .m02   (m02),
        .m10   (m10),
        .m11   (m11),
        .m12   (m12),
        .busy  (busy),
        .co    (coord_link.source)
    );

    texel_fetch #(
        .TEX_X_BITS (TEX_X_BITS),
        .TEX_Y_BITS (TEX_Y_BITS)
    ) i_texel_fetch (
        .clk       (clk),
        .reset     (reset),
        .tex_we    (tex_we),
        .tex_waddr (tex_waddr),
        .tex_wdata (tex_wdata),
        .ci        (coord_link.sink),
        .qo        (quad_link.source)
    );

    bilinear_blend i_bilinear_blend (
        .clk          (clk),
        .reset        (reset),
        .border_value (border_value),
        .qi           (quad_link.sink),
        .data         (out_data),
        .border       (out_border),
        .last         (out_last),
        .valid        (out_valid),
        .ready        (out_ready)
    );

endmodule

// File: verif/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// File: verif/tex_sampler_checker.sv
module tex_sampler_checker
    import tex_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   start,
    input logic   busy,
    input pixel_t out_data,
    input logic   out_border,
    input logic   out_last,
    input logic   out_valid,
    input logic   out_ready
);

    // stalled output holds its item
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
            && $stable(out_border) && $stable(out_last))
        else $error("output item changed while out_ready was low");

    a_reset_idle: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high during reset");

    // busy only rises on start, so a fall always follows a start
    a_busy_start: assert property (@(posedge clk) disable iff (reset)
        !busy && !start |=> !busy)
        else $error("busy rose without start");

endmodule

bind tex_sampler_top tex_sampler_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .busy       (busy),
    .out_data   (out_data),
    .out_border (out_border),
    .out_last   (out_last),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
);

// File: verif/tb_top.sv
module tb_top
    import tex_pkg::*;
#(
    parameter int TEX_X_BITS = 4,
    parameter int TEX_Y_BITS = 4,
    parameter int OUT_W      = 16,
    parameter int OUT_H      = 16
);

    localparam int AW       = TEX_X_BITS + TEX_Y_BITS;
    localparam int TEX_W    = 1 << TEX_X_BITS;
    localparam int TEX_H    = 1 << TEX_Y_BITS;
    localparam int FRAME    = OUT_W * OUT_H;
    localparam int N_TESTS  = 5;
    localparam int WATCHDOG = N_TESTS * FRAME * 4 + 1000;

    logic          clk;
    logic          reset;
    logic          start;
    logic          tex_we;
    logic [AW-1:0] tex_waddr;
    pixel_t        tex_wdata;
    coef_t         m00, m01, m02, m10, m11, m12;
    pixel_t        border_value;
    logic          out_ready;
    logic          busy;
    pixel_t        out_data;
    logic          out_border;
    logic          out_last;
    logic          out_valid;

    pixel_t        tex_copy [TEX_W * TEX_H];
    logic [31:0]   seed;
    logic [8:0]    exp_px;      // {border, data}
    int            cx = 0;
    int            cy = 0;
    int            n_out = 0;
    int            mismatches = 0;
    int            failures = 0;

    tb_clock #(.PERIOD(100)) i_clock (.clk(clk));

    tex_sampler_top #(
        .TEX_X_BITS (TEX_X_BITS),
        .TEX_Y_BITS (TEX_Y_BITS),
        .OUT_W      (OUT_W),
        .OUT_H      (OUT_H)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .tex_we       (tex_we),
        .tex_waddr    (tex_waddr),
        .tex_wdata    (tex_wdata),
        .m00          (m00),
        .m01          (m01),
        .m02          (m02),
        .m10          (m10),
        .m11          (m11),
        .m12          (m12),
        .border_value (border_value),
        .out_ready    (out_ready),
        .busy         (busy),
        .out_data     (out_data),
        .out_border   (out_border),
        .out_last     (out_last),
        .out_valid    (out_valid)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    function automatic int texel(input int x, input int y);
        return int'(tex_copy[AW'(y * TEX_W + x)]);
    endfunction

    // ----------------------------------------
    // expected pixel at raster position (x, y)
    // ----------------------------------------
    function automatic logic [8:0] ref_pixel(input int x, input int y);
        int u, v, x0, y0, x1, y1, fu, fv, acc;
        u  = int'(m00) * x + int'(m01) * y + int'(m02);
        v  = int'(m10) * x + int'(m11) * y + int'(m12);
        x0 = u >>> 4;   // floor of the 1/16 coordinate
        y0 = v >>> 4;
        fu = u & 15;
        fv = v & 15;
        if (x0 < 0 || y0 < 0 || x0 >= TEX_W || y0 >= TEX_H) begin
            return {1'b1, border_value};
        end
        x1  = (x0 < TEX_W - 1) ? x0 + 1 : TEX_W - 1;
        y1  = (y0 < TEX_H - 1) ? y0 + 1 : TEX_H - 1;
        acc = texel(x0, y0) * (16 - fu) * (16 - fv) + texel(x1, y0) * fu * (16 - fv)
            + texel(x0, y1) * (16 - fu) * fv + texel(x1, y1) * fu * fv + 128;
        return {1'b0, 8'(acc / 256)};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s at pixel (%0d, %0d): got %0h, expected %0h",
                     name, cx, cy, got, exp);
            mismatches++;
        end
    endtask

    // compare each output transfer against its raster position
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            exp_px = ref_pixel(cx, cy);
            check("out_data", 32'(out_data), 32'(exp_px[7:0]));
            check("out_border", 32'(out_border), 32'(exp_px[8]));
            check("out_last", 32'(out_last), 32'(cx == OUT_W - 1 && cy == OUT_H - 1));
            n_out++;
            if (cx == OUT_W - 1) begin
                cx = 0;
                cy = (cy == OUT_H - 1) ? 0 : cy + 1;
            end else begin
                cx++;
            end
        end
    end

    task automatic fill_texture();
        for (int a = 0; a < TEX_W * TEX_H; a++) begin
            seed = xorshift(seed);
            tex_copy[AW'(a)] = seed[7:0];
            tex_we    = 1'b1;
            tex_waddr = AW'(a);
            tex_wdata = seed[7:0];
            @(negedge clk);
        end
        tex_we = 1'b0;
    endtask

    task automatic set_matrix(input int a00, input int a01, input int a02,
                              input int a10, input int a11, input int a12,
                              input int bv);
        m00          = coef_t'(a00);
        m01          = coef_t'(a01);
        m02          = coef_t'(a02);
        m10          = coef_t'(a10);
        m11          = coef_t'(a11);
        m12          = coef_t'(a12);
        border_value = pixel_t'(bv);
    endtask

    // run one frame with optional random stalls on out_ready
    task automatic run_frame(input logic stall);
        int target;
        target = n_out + FRAME;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (n_out < target) begin
            if (stall) begin
                seed      = xorshift(seed);
                out_ready = seed[3];
            end
            @(negedge clk);
        end
        out_ready = 1'b1;
        repeat (4) @(negedge clk);
        if (n_out != target) begin
            $display("frame gave %0d transfers instead of %0d", n_out - target + FRAME, FRAME);
            failures++;
        end
        if (busy || out_valid) begin
            $display("busy or out_valid still high after the frame");
            failures++;
        end
    endtask

    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        tex_we    = 1'b0;
        tex_waddr = '0;
        tex_wdata = '0;
        out_ready = 1'b1;
        seed      = 32'hd598bb3e;
        set_matrix(0, 0, 0, 0, 0, 0, 0);
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (busy || out_valid) begin
            $display("busy or out_valid high after reset");
            failures++;
        end
        fill_texture();

        set_matrix(16, 0, 0, 0, 16, 0, 8'h00);        // identity
        run_frame(1'b0);
        set_matrix(11, -11, 117, 11, 11, -3, 8'h11);  // about 45 degrees
        run_frame(1'b0);
        set_matrix(19, 2, -40, -1, 18, -70, 8'h5a);   // negative offsets
        run_frame(1'b0);
        set_matrix(19, 2, -40, -1, 18, -70, 8'hc3);
        run_frame(1'b0);
        set_matrix(11, -11, 117, 11, 11, -3, 8'h77);
        run_frame(1'b1);

        $display("mismatches %0d, other failures %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", WATCHDOG);
        $display("Errors found");
        $finish;
    end

endmodule

// File: all.f
logic/tex_pkg.sv
logic/tex_ifs.sv
logic/affine_scan.sv
logic/texture_mem.sv
logic/texel_fetch.sv
logic/bilinear_blend.sv
logic/tex_sampler_top.sv
verif/tb_clock.sv
verif/tex_sampler_checker.sv
verif/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_top
FILELIST  := all.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
